/* beamformer_pkg.sv */
////////////////////
// shared widths, counts and vector types of the four-channel beamformer
// weights are Q1.7, so 127 is the largest gain and -128 means -1.0
// every stream word packs eight 16-bit lanes, lane i in bits 16i+15:16i
////////////////////
package beamformer_pkg;

    // number of antenna channels combined into the single output stream
    localparam int NUM_CHANNELS = 4;

    // one real or imaginary sample is a signed 16-bit value
    localparam int SAMPLE_WIDTH = 16;

    // eight sample lanes travel in each stream beat
    localparam int SAMPLES = 8;

    // full stream word, eight lanes side by side
    localparam int DATA_WIDTH = SAMPLES * SAMPLE_WIDTH;

    // each part of a complex weight is a signed 8-bit value
    localparam int WEIGHT_WIDTH = 8;

    // fractional bits of a weight, so the product is shifted back by this much
    localparam int WEIGHT_FRAC = 7;

    // four 16-bit lane values need two guard bits when they are added
    localparam int SUM_WIDTH = SAMPLE_WIDTH + 2;

    // shift applied after the channel sum, a divide by four
    localparam int COMBINE_SHIFT = 2;

    // input register, product register, rescale register and output register
    localparam int PIPE_STAGES = 4;

    // a single signed lane value
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // a single signed weight part
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // full-precision product of a sample and a weight part
    typedef logic signed [SAMPLE_WIDTH+WEIGHT_WIDTH-1:0] product_t;

    // sum or difference of two products, one bit wider so it cannot overflow
    typedef logic signed [SAMPLE_WIDTH+WEIGHT_WIDTH:0] cross_sum_t;

    // lane sum over all channels
    typedef logic signed [SUM_WIDTH-1:0] lane_sum_t;

    // a whole 128-bit stream word
    typedef logic [DATA_WIDTH-1:0] data_word_t;

endpackage

/* sample_complex_mult.sv */
////////////////////
// one lane of the complex weight multiply, two register stages deep
// results wrap to 16 bits after the Q1.7 rescale, nothing saturates
////////////////////
module sample_complex_mult (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    enable,
    input  beamformer_pkg::sample_t x_real,
    input  beamformer_pkg::sample_t x_imag,
    input  beamformer_pkg::weight_t w_real,
    input  beamformer_pkg::weight_t w_imag,
    output beamformer_pkg::sample_t y_real,
    output beamformer_pkg::sample_t y_imag
);
    import beamformer_pkg::*;

    // the four partial products of (xr + j xi) * (wr + j wi)
    product_t prod_rr;
    product_t prod_ii;
    product_t prod_ri;
    product_t prod_ir;

    // real and imaginary results before the rescale
    cross_sum_t cross_real;
    cross_sum_t cross_imag;

    // stage 2 holds the products
    // both operands are widened to the product type first so the multiply is
    // done signed at full width
    always_ff @(posedge clock) begin
        if (!resetn) begin
            prod_rr <= '0;
            prod_ii <= '0;
            prod_ri <= '0;
            prod_ir <= '0;
        end else if (enable) begin
            prod_rr <= product_t'(x_real) * product_t'(w_real);
            prod_ii <= product_t'(x_imag) * product_t'(w_imag);
            prod_ri <= product_t'(x_real) * product_t'(w_imag);
            prod_ir <= product_t'(x_imag) * product_t'(w_real);
        end
    end

    // real part is xr*wr - xi*wi and imaginary part is xr*wi + xi*wr
    assign cross_real = cross_sum_t'(prod_rr) - cross_sum_t'(prod_ii);
    assign cross_imag = cross_sum_t'(prod_ri) + cross_sum_t'(prod_ir);

    // stage 3 drops the seven fraction bits with an arithmetic shift
    // and keeps only the low 16 bits, so large results wrap around
    always_ff @(posedge clock) begin
        if (!resetn) begin
            y_real <= '0;
            y_imag <= '0;
        end else if (enable) begin
            y_real <= sample_t'(cross_real >>> WEIGHT_FRAC);
            y_imag <= sample_t'(cross_imag >>> WEIGHT_FRAC);
        end
    end

endmodule

/* channel_weighter.sv */
////////////////////
// applies one complex weight to all eight lanes of one channel
// weights are sampled every enabled edge, so change them only while idle
////////////////////
module channel_weighter (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       enable,
    input  logic                       accept,
    input  beamformer_pkg::data_word_t in_real,
    input  beamformer_pkg::data_word_t in_imag,
    input  beamformer_pkg::weight_t    weight_real,
    input  beamformer_pkg::weight_t    weight_imag,
    output beamformer_pkg::data_word_t out_real,
    output beamformer_pkg::data_word_t out_imag
);
    import beamformer_pkg::*;

    // stage 1 copies of the input words
    data_word_t real_q;
    data_word_t imag_q;

    // stage 1 copies of the weight, lined up with the data they scale
    weight_t w_real_q;
    weight_t w_imag_q;

    // per-lane results coming back from the multipliers
    sample_t lane_real [SAMPLES];
    sample_t lane_imag [SAMPLES];

    // stage 1 register
    // an enabled edge without an accepted beat loads zeros, so an empty slot
    // moves down the pipe as an all-zero word
    always_ff @(posedge clock) begin
        if (!resetn) begin
            real_q   <= '0;
            imag_q   <= '0;
            w_real_q <= '0;
            w_imag_q <= '0;
        end else if (enable) begin
            w_real_q <= weight_real;
            w_imag_q <= weight_imag;
            if (accept) begin
                real_q <= in_real;
                imag_q <= in_imag;
            end else begin
                real_q <= '0;
                imag_q <= '0;
            end
        end
    end

    // one multiplier per lane, every lane sees the same weight
    for (genvar lane = 0; lane < SAMPLES; lane++) begin : g_lane
        sample_complex_mult lane_mult_i (
            .clock  (clock),
            .resetn (resetn),
            .enable (enable),
            .x_real (sample_t'(real_q[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH])),
            .x_imag (sample_t'(imag_q[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH])),
            .w_real (w_real_q),
            .w_imag (w_imag_q),
            .y_real (lane_real[lane]),
            .y_imag (lane_imag[lane])
        );
    end

    // put the lanes back into stream words in the same bit positions
    always_comb begin
        for (int lane = 0; lane < SAMPLES; lane++) begin
            out_real[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lane_real[lane];
            out_imag[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lane_imag[lane];
        end
    end

endmodule

/* channel_combiner.sv */
////////////////////
// adds the weighted channels lane by lane and divides by four
// the shift floors toward minus infinity, like any arithmetic shift
////////////////////
module channel_combiner (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       enable,
    input  beamformer_pkg::data_word_t ch_real [beamformer_pkg::NUM_CHANNELS],
    input  beamformer_pkg::data_word_t ch_imag [beamformer_pkg::NUM_CHANNELS],
    output beamformer_pkg::data_word_t m_real,
    output beamformer_pkg::data_word_t m_imag
);
    import beamformer_pkg::*;

    // scaled sum words waiting for the output register
    data_word_t next_real;
    data_word_t next_imag;

    // the lane sum is 18 bits wide so four full-scale values cannot overflow
    // each channel sample is read as signed and sign-extended before the add
    always_comb begin
        lane_sum_t acc_real;
        lane_sum_t acc_imag;
        next_real = '0;
        next_imag = '0;
        for (int lane = 0; lane < SAMPLES; lane++) begin
            acc_real = '0;
            acc_imag = '0;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                acc_real = acc_real + lane_sum_t'(
                    sample_t'(ch_real[ch][lane*SAMPLE_WIDTH +: SAMPLE_WIDTH]));
                acc_imag = acc_imag + lane_sum_t'(
                    sample_t'(ch_imag[ch][lane*SAMPLE_WIDTH +: SAMPLE_WIDTH]));
            end
            // after the shift the value fits back into 16 bits, take the low part
            next_real[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] =
                sample_t'(acc_real >>> COMBINE_SHIFT);
            next_imag[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] =
                sample_t'(acc_imag >>> COMBINE_SHIFT);
        end
    end

    // stage 4 is the output register, it holds while the sink stalls
    always_ff @(posedge clock) begin
        if (!resetn) begin
            m_real <= '0;
            m_imag <= '0;
        end else if (enable) begin
            m_real <= next_real;
            m_imag <= next_imag;
        end
    end

endmodule

/* beamformer_pipeline_ctrl.sv */
////////////////////
// handshake and valid tracking for the four-stage pipeline
// a beat needs all four channel valids at once, there is no skew buffer
// the whole pipe stalls with m_ready low, even when it is empty
////////////////////
module beamformer_pipeline_ctrl (
    input  logic clock,
    input  logic resetn,
    input  logic s_valid [beamformer_pkg::NUM_CHANNELS],
    input  logic s_last,
    input  logic m_ready,
    output logic s_ready,
    output logic enable,
    output logic accept,
    output logic m_valid,
    output logic m_last
);
    import beamformer_pkg::*;

    // set on the first edge after reset is released, keeps s_ready low until then
    logic running;

    // high when every channel offers a beat in this cycle
    logic all_valid;

    // valid and last bits travelling beside the data, bit 0 is stage 1
    logic [PIPE_STAGES-1:0] valid_pipe;
    logic [PIPE_STAGES-1:0] last_pipe;

    always_comb begin
        all_valid = 1'b1;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            all_valid = all_valid & s_valid[ch];
        end
    end

    // the pipeline has no skid buffer, so the input can only take a beat when
    // the whole pipe is allowed to move
    assign enable  = m_ready;
    assign s_ready = m_ready & running;

    // the single place where a beat is judged to be taken
    assign accept = s_ready & all_valid;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            running    <= 1'b0;
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            running <= 1'b1;
            // both bits move one stage per enabled edge, in step with the data
            if (enable) begin
                valid_pipe <= {valid_pipe[PIPE_STAGES-2:0], accept};
                last_pipe  <= {last_pipe[PIPE_STAGES-2:0], accept & s_last};
            end
        end
    end

    // the last stage lines up with the combiner output register
    assign m_valid = valid_pipe[PIPE_STAGES-1];
    assign m_last  = last_pipe[PIPE_STAGES-1];

endmodule

/* beamformer_top.sv */
////////////////////
// four-channel complex beamformer with one shared ready
// latency is four enabled edges from accept to output
// weights must be stable while beats are in flight
////////////////////
module beamformer_top (
    input  logic                       clock,
    input  logic                       resetn,

    // input streams, one per channel, all handed over together
    input  logic                       s_valid     [beamformer_pkg::NUM_CHANNELS],
    input  logic                       s_last,
    output logic                       s_ready,
    input  beamformer_pkg::data_word_t s_real      [beamformer_pkg::NUM_CHANNELS],
    input  beamformer_pkg::data_word_t s_imag      [beamformer_pkg::NUM_CHANNELS],

    // one complex Q1.7 weight per channel
    input  beamformer_pkg::weight_t    weight_real [beamformer_pkg::NUM_CHANNELS],
    input  beamformer_pkg::weight_t    weight_imag [beamformer_pkg::NUM_CHANNELS],

    // combined output stream
    output logic                       m_valid,
    output logic                       m_last,
    input  logic                       m_ready,
    output beamformer_pkg::data_word_t m_real,
    output beamformer_pkg::data_word_t m_imag
);
    import beamformer_pkg::*;

    // pipeline advance and beat accept, both from the control block
    logic enable;
    logic accept;

    // weighted words of each channel after stage 3
    data_word_t weighted_real [NUM_CHANNELS];
    data_word_t weighted_imag [NUM_CHANNELS];

    // handshake, stall and valid tracking
    beamformer_pipeline_ctrl pipeline_ctrl_i (
        .clock   (clock),
        .resetn  (resetn),
        .s_valid (s_valid),
        .s_last  (s_last),
        .m_ready (m_ready),
        .s_ready (s_ready),
        .enable  (enable),
        .accept  (accept),
        .m_valid (m_valid),
        .m_last  (m_last)
    );

    // stages 1 to 3 for every channel
    // all channels share the accept, since a beat is only taken when all are valid
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        channel_weighter channel_weighter_i (
            .clock       (clock),
            .resetn      (resetn),
            .enable      (enable),
            .accept      (accept),
            .in_real     (s_real[ch]),
            .in_imag     (s_imag[ch]),
            .weight_real (weight_real[ch]),
            .weight_imag (weight_imag[ch]),
            .out_real    (weighted_real[ch]),
            .out_imag    (weighted_imag[ch])
        );
    end

    // stage 4, channel sum and output register
    channel_combiner channel_combiner_i (
        .clock   (clock),
        .resetn  (resetn),
        .enable  (enable),
        .ch_real (weighted_real),
        .ch_imag (weighted_imag),
        .m_real  (m_real),
        .m_imag  (m_imag)
    );

endmodule

/* beamformer_checker.sv */
////////////////////
// protocol checks bound into every beamformer_top instance
// the ready rule skips the first cycle after reset, when the control starts up
////////////////////
module beamformer_checker (
    input logic                       clock,
    input logic                       resetn,
    input logic                       s_ready,
    input logic                       m_valid,
    input logic                       m_ready,
    input logic                       m_last,
    input beamformer_pkg::data_word_t m_real,
    input beamformer_pkg::data_word_t m_imag
);

    // a reset edge clears the pipe, and s_ready stays low for one more cycle
    reset_outputs_low: assert property (@(posedge clock)
        !resetn |=> !s_ready && !m_valid && !m_last)
        else $error("s_ready, m_valid or m_last was high after a reset edge");

    // a stalled output beat must not change before the sink takes it
    stall_holds_output: assert property (@(posedge clock) disable iff (!resetn)
        m_valid && !m_ready |=> $stable(m_valid) && $stable(m_last)
            && $stable(m_real) && $stable(m_imag))
        else $error("output beat changed while m_ready was low");

    // the input side follows the sink once the control is running
    ready_follows_sink: assert property (@(posedge clock) disable iff (!resetn)
        $past(resetn) |-> s_ready == m_ready)
        else $error("s_ready differs from m_ready outside reset");

endmodule

bind beamformer_top beamformer_checker beamformer_checker_i (
    .clock   (clock),
    .resetn  (resetn),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_real  (m_real),
    .m_imag  (m_imag)
);

/* beamformer_tb.sv */
////////////////////
// drives random beats through the beamformer and checks every output beat
// against a model of the weighting and combining rules
// weights change only while the pipeline is empty, between tests
////////////////////
module beamformer_tb;
    import beamformer_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int DRIVE_DELAY   = 2;
    localparam int BEATS_UNIT    = 40;
    localparam int BEATS_FULL    = 64;
    localparam int BEATS_STALL   = 64;
    localparam int BEATS_EXTREME = 48;
    localparam int BEATS_LAST    = 48;
    localparam int TOTAL_BEATS   = BEATS_UNIT + BEATS_FULL + BEATS_STALL
                                   + BEATS_EXTREME + BEATS_LAST;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 200;

    // a beat taken at one edge shows up after the fourth edge from there
    localparam int LATENCY_CYCLES = 4;

    logic       clock;
    logic       resetn;
    logic       s_valid     [NUM_CHANNELS];
    logic       s_last;
    logic       s_ready;
    data_word_t s_real      [NUM_CHANNELS];
    data_word_t s_imag      [NUM_CHANNELS];
    weight_t    weight_real [NUM_CHANNELS];
    weight_t    weight_imag [NUM_CHANNELS];
    logic       m_valid;
    logic       m_last;
    logic       m_ready;
    data_word_t m_real;
    data_word_t m_imag;

    // expected output beats in the order they were accepted
    data_word_t exp_real_q [$];
    data_word_t exp_imag_q [$];
    logic       exp_last_q [$];

    logic [31:0] lcg_state = 32'd13352;
    string       current_test = "none";
    int          error_count = 0;
    int          checks_run = 0;
    int          tests_run = 0;
    int          test_errors = 0;
    int          test_in = 0;
    int          test_out = 0;
    int          cycle_count = 0;
    int          first_in_cycle = -1;
    int          first_out_cycle = -1;
    int          last_out_cycle = -1;

    beamformer_top beamformer_top_i (
        .clock       (clock),
        .resetn      (resetn),
        .s_valid     (s_valid),
        .s_last      (s_last),
        .s_ready     (s_ready),
        .s_real      (s_real),
        .s_imag      (s_imag),
        .weight_real (weight_real),
        .weight_imag (weight_imag),
        .m_valid     (m_valid),
        .m_last      (m_last),
        .m_ready     (m_ready),
        .m_real      (m_real),
        .m_imag      (m_imag)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // the watchdog length follows from the beat counts of all tests
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // full-period LCG whose upper bits are used since the low bits repeat quickly
    function automatic logic [31:0] rand_bits();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = rand_bits();
        return (int'(r[31:16]) % 100) < pct;
    endfunction

    // extreme samples are full-scale negative or full-scale positive
    function automatic sample_t random_sample(input bit extreme);
        logic [31:0] r;
        r = rand_bits();
        if (extreme) begin
            return r[31] ? 16'sh8000 : 16'sh7fff;
        end
        return sample_t'(r[31:16]);
    endfunction

    function automatic data_word_t random_word(input bit extreme);
        data_word_t w;
        for (int lane = 0; lane < SAMPLES; lane++) begin
            w[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] = random_sample(extreme);
        end
        return w;
    endfunction

    function automatic weight_t random_weight(input bit extreme);
        logic [31:0] r;
        r = rand_bits();
        if (extreme) begin
            return r[31] ? 8'sh80 : 8'sh7f;
        end
        return weight_t'(r[31:24]);
    endfunction

    function automatic bit all_channels_valid();
        bit all;
        all = 1'b1;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            all = all & s_valid[ch];
        end
        return all;
    endfunction

    // complex product per channel with a Q1.7 rescale and 16-bit wrap,
    // then the four channels summed and floored by a divide by four
    function automatic void model_beat(output data_word_t exp_re, output data_word_t exp_im);
        int      xr;
        int      xi;
        int      wr;
        int      wi;
        int      acc_re;
        int      acc_im;
        sample_t wrapped;
        exp_re = '0;
        exp_im = '0;
        for (int lane = 0; lane < SAMPLES; lane++) begin
            acc_re = 0;
            acc_im = 0;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                xr = int'(sample_t'(s_real[ch][lane*SAMPLE_WIDTH +: SAMPLE_WIDTH]));
                xi = int'(sample_t'(s_imag[ch][lane*SAMPLE_WIDTH +: SAMPLE_WIDTH]));
                wr = int'(weight_real[ch]);
                wi = int'(weight_imag[ch]);
                wrapped = 16'((xr * wr - xi * wi) >>> WEIGHT_FRAC);
                acc_re = acc_re + int'(wrapped);
                wrapped = 16'((xr * wi + xi * wr) >>> WEIGHT_FRAC);
                acc_im = acc_im + int'(wrapped);
            end
            exp_re[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'(acc_re >>> COMBINE_SHIFT);
            exp_im[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'(acc_im >>> COMBINE_SHIFT);
        end
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_word(input string what, input data_word_t expected,
                              input data_word_t actual);
        checks_run++;
        assert (actual == expected) else begin
            $display("ERR %s %s expected %h actual %h", current_test, what, expected, actual);
            count_error();
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks_run++;
        assert (actual == expected) else begin
            $display("ERR %s %s expected %0d actual %0d", current_test, what, expected, actual);
            count_error();
        end
    endtask

    // sampled at the falling edge, where inputs and outputs are both settled
    // and hold the values that the next rising edge will take
    always @(negedge clock) begin : monitor
        data_word_t exp_re;
        data_word_t exp_im;
        cycle_count++;
        if (resetn && m_valid && m_ready) begin
            assert (exp_real_q.size() > 0) else begin
                $display("test %s sent an output beat that was never accepted", current_test);
                count_error();
            end
            if (exp_real_q.size() > 0) begin
                check_word("m_real", exp_real_q.pop_front(), m_real);
                check_word("m_imag", exp_imag_q.pop_front(), m_imag);
                check_word("m_last", 128'(exp_last_q.pop_front()), 128'(m_last));
            end
            if (first_out_cycle < 0) begin
                first_out_cycle = cycle_count;
            end
            last_out_cycle = cycle_count;
            test_out++;
        end
        if (resetn && s_ready && all_channels_valid()) begin
            model_beat(exp_re, exp_im);
            exp_real_q.push_back(exp_re);
            exp_imag_q.push_back(exp_im);
            exp_last_q.push_back(s_last);
            if (first_in_cycle < 0) begin
                first_in_cycle = cycle_count;
            end
            test_in++;
        end
    end

    task automatic drive_idle();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            s_valid[ch] = 1'b0;
        end
        s_last  = 1'b0;
        m_ready = 1'b1;
    endtask

    task automatic drive_beat(input int valid_pct, input int ready_pct,
                              input int last_pct, input bit extreme);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            s_valid[ch] = chance(valid_pct);
            s_real[ch]  = random_word(extreme);
            s_imag[ch]  = random_word(extreme);
        end
        s_last  = chance(last_pct);
        m_ready = chance(ready_pct);
    endtask

    // only channel 0 passes, with a gain of 127/128
    task automatic set_unit_weights();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            weight_real[ch] = (ch == 0) ? 8'sd127 : 8'sd0;
            weight_imag[ch] = 8'sd0;
        end
    endtask

    task automatic set_random_weights(input bit extreme);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            weight_real[ch] = random_weight(extreme);
            weight_imag[ch] = random_weight(extreme);
        end
    endtask

    // lets the sink take everything still in flight, then ends after a drive delay
    task automatic wait_drain();
        m_ready = 1'b1;
        while (exp_real_q.size() > 0) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic report_test();
        tests_run++;
        $display("test %s: %0d beats in, %0d beats out, %0d errors",
                 current_test, test_in, test_out, test_errors);
    endtask

    task automatic run_test(input string name, input int beats, input int valid_pct,
                            input int ready_pct, input int last_pct, input bit extreme,
                            input bit back_to_back);
        current_test    = name;
        test_errors     = 0;
        test_in         = 0;
        test_out        = 0;
        first_in_cycle  = -1;
        first_out_cycle = -1;
        last_out_cycle  = -1;
        // the accept count moves at the falling edge, so the last beat is
        // followed straight away by idle inputs
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
            if (test_in < beats) begin
                drive_beat(valid_pct, ready_pct, last_pct, extreme);
            end else begin
                drive_idle();
            end
        end while (test_in < beats);
        wait_drain();
        check_count("beats out", test_in, test_out);
        if (back_to_back) begin
            check_count("output span in cycles", beats, last_out_cycle - first_out_cycle + 1);
            check_count("latency in cycles", LATENCY_CYCLES, first_out_cycle - first_in_cycle);
        end
        report_test();
    endtask

    initial begin
        resetn = 1'b0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            s_real[ch] = '0;
            s_imag[ch] = '0;
        end
        set_unit_weights();
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        resetn = 1'b1;

        // one cycle after release the control has not started yet
        @(negedge clock);
        current_test = "reset_state";
        check_word("s_ready", '0, 128'(s_ready));
        check_word("m_valid", '0, 128'(m_valid));
        check_word("m_last", '0, 128'(m_last));
        check_word("m_real", '0, m_real);
        check_word("m_imag", '0, m_imag);
        report_test();
        @(posedge clock);
        #DRIVE_DELAY;

        set_unit_weights();
        run_test("unit_weight", BEATS_UNIT, 100, 100, 0, 1'b0, 1'b0);
        set_random_weights(1'b0);
        run_test("random_full", BEATS_FULL, 100, 100, 0, 1'b0, 1'b1);
        set_random_weights(1'b0);
        run_test("random_stall", BEATS_STALL, 85, 70, 0, 1'b0, 1'b0);
        set_random_weights(1'b1);
        run_test("extreme_values", BEATS_EXTREME, 90, 90, 0, 1'b1, 1'b0);
        set_random_weights(1'b0);
        run_test("random_last", BEATS_LAST, 90, 80, 30, 1'b0, 1'b0);

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks_run, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* beamformer.f */
beamformer_pkg.sv
sample_complex_mult.sv
channel_weighter.sv
channel_combiner.sv
beamformer_pipeline_ctrl.sv
beamformer_top.sv
beamformer_checker.sv
beamformer_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the beamformer testbench with Verilator and run it
# the run counts as passed only when the log holds the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module beamformer_tb \
    -f beamformer.f \
    -o beamformer_sim

# keep going after a failing run so the log can still be searched
sim_status=0
./obj_dir/beamformer_sim > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed, exit status $sim_status"
    exit 1
fi
